// ==== hw/flush_pkg.sv ====
package flush_pkg;

   // default geometry, log2 of the line count per level
   localparam int lg_l1i_lines_default = 4;
   localparam int lg_l1d_lines_default = 4;

   // must not be smaller than the l1d value, wb lines are zero-extended
   localparam int lg_l2_lines_default = 6;

   // flush sequencer states
   typedef enum logic [2:0] {
      flush_idle = 3'd0,
      wait_both  = 3'd1, // both l1 flushes outstanding
      got_l1d    = 3'd2, // l1d done, waiting on l1i
      got_l1i    = 3'd3, // l1i done, waiting on l1d
      flush_l2   = 3'd4
   } flush_state_t;

endpackage

// ==== hw/line_walker.sv ====
module line_walker
  #(parameter type index_t = logic [3:0])
   (
   input  logic   clk,
   input  logic   reset,
   input  logic   start,
   input  logic   mark_req,
   input  index_t mark_index,
   input  logic   emit_ack,
   output logic   mark_ack,
   output logic   emit_req,
   output index_t emit_index,
   output logic   done
   );

   localparam int lg_lines = $bits(index_t);
   localparam int num_lines = 1 << lg_lines;

   typedef enum logic [1:0] {
      walk_idle,
      walk_scan,
      walk_wait_ack,
      walk_wait_low
   } walk_state_t;

   walk_state_t r_state, n_state;
   index_t r_cursor, n_cursor;
   logic [num_lines-1:0] r_lines;
   logic r_mark_ack;
   logic r_emit_req, n_emit_req;
   logic r_done, n_done;
   logic mark_accept;
   logic line_clear;
   logic last_line;

   assign mark_ack = r_mark_ack;
   assign emit_req = r_emit_req;
   assign emit_index = r_cursor; // cursor holds still during a handshake
   assign done = r_done;

   // take a mark only while ack is low
   assign mark_accept = mark_req && !r_mark_ack;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_mark_ack <= 1'b0;
      end
      else if (mark_accept)
      begin
         r_mark_ack <= 1'b1;
      end
      else if (!mark_req)
      begin
         r_mark_ack <= 1'b0; // source dropped req
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_lines <= '0;
      end
      else
      begin
         if (line_clear)
            r_lines[r_cursor] <= 1'b0;
         if (mark_accept)
            r_lines[mark_index] <= 1'b1; // new mark wins over a clear
      end
   end

   assign last_line = (r_cursor == index_t'(num_lines - 1));

   always_comb
   begin
      n_state = r_state;
      n_cursor = r_cursor;
      n_emit_req = r_emit_req;
      n_done = 1'b0;
      line_clear = 1'b0;

      case (r_state)
         walk_idle:
         begin
            if (start)
            begin
               n_cursor = '0;
               n_state = walk_scan;
            end
         end
         walk_scan:
         begin
            if (r_lines[r_cursor])
            begin
               n_emit_req = 1'b1;
               n_state = walk_wait_ack;
            end
            else if (last_line)
            begin
               n_done = 1'b1;
               n_state = walk_idle;
            end
            else
            begin
               n_cursor = index_t'(r_cursor + 1'b1);
            end
         end
         walk_wait_ack:
         begin
            if (emit_ack)
            begin
               n_emit_req = 1'b0;
               n_state = walk_wait_low;
            end
         end
         walk_wait_low:
         begin
            // sink has released ack, line is written back
            if (!emit_ack)
            begin
               line_clear = 1'b1;
               if (last_line)
               begin
                  n_done = 1'b1;
                  n_state = walk_idle;
               end
               else
               begin
                  n_cursor = index_t'(r_cursor + 1'b1);
                  n_state = walk_scan;
               end
            end
         end
         default:
         begin
            n_emit_req = 1'b0;
            n_state = walk_idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= walk_idle;
         r_cursor <= '0;
         r_emit_req <= 1'b0;
         r_done <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_cursor <= n_cursor;
         r_emit_req <= n_emit_req;
         r_done <= n_done;
      end
   end

endmodule

// ==== hw/flush_sequencer.sv ====
module flush_sequencer
   (
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic done_l1i,
   input  logic done_l1d,
   input  logic done_l2,
   output logic start_l1i,
   output logic start_l1d,
   output logic start_l2,
   output logic in_flush_mode
   );

   import flush_pkg::*;

   flush_state_t r_state, n_state;
   logic r_flush, n_flush;
   logic r_start_l1i, n_start_l1i;
   logic r_start_l1d, n_start_l1d;
   logic r_start_l2, n_start_l2;

   assign in_flush_mode = r_flush;
   assign start_l1i = r_start_l1i;
   assign start_l1d = r_start_l1d;
   assign start_l2 = r_start_l2;

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_start_l1i = 1'b0;
      n_start_l1d = 1'b0;
      n_start_l2 = 1'b0;

      case (r_state)
         flush_idle:
         begin
            // a missing request counts as that level already flushed
            if (flush_req_l1i || flush_req_l1d)
            begin
               n_flush = 1'b1;
               n_start_l1i = flush_req_l1i;
               n_start_l1d = flush_req_l1d;
               if (flush_req_l1i && flush_req_l1d)
                  n_state = wait_both;
               else if (flush_req_l1i)
                  n_state = got_l1d;
               else
                  n_state = got_l1i;
            end
         end
         wait_both:
         begin
            if (done_l1i && done_l1d)
            begin
               n_start_l2 = 1'b1;
               n_state = flush_l2;
            end
            else if (done_l1d)
            begin
               n_state = got_l1d;
            end
            else if (done_l1i)
            begin
               n_state = got_l1i;
            end
         end
         got_l1d:
         begin
            if (done_l1i)
            begin
               n_start_l2 = 1'b1;
               n_state = flush_l2;
            end
         end
         got_l1i:
         begin
            if (done_l1d)
            begin
               n_start_l2 = 1'b1;
               n_state = flush_l2;
            end
         end
         flush_l2:
         begin
            if (done_l2)
            begin
               n_flush = 1'b0;
               n_state = flush_idle;
            end
         end
         default:
         begin
            n_flush = 1'b0;
            n_state = flush_idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= flush_idle;
         r_flush <= 1'b0;
         r_start_l1i <= 1'b0;
         r_start_l1d <= 1'b0;
         r_start_l2 <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_start_l1i <= n_start_l1i;
         r_start_l1d <= n_start_l1d;
         r_start_l2 <= n_start_l2;
      end
   end

endmodule

// ==== hw/cache_flush_top.sv ====
module cache_flush_top
  #(parameter int lg_l1i_lines = flush_pkg::lg_l1i_lines_default,
    parameter int lg_l1d_lines = flush_pkg::lg_l1d_lines_default,
    parameter int lg_l2_lines  = flush_pkg::lg_l2_lines_default)
   (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    flush_req_l1i,
   input  logic                    flush_req_l1d,

   // fills into l1i
   input  logic                    fill_req,
   input  logic [lg_l1i_lines-1:0] fill_line,
   output logic                    fill_ack,

   // stores into l1d
   input  logic                    store_req,
   input  logic [lg_l1d_lines-1:0] store_line,
   output logic                    store_ack,

   // l1i invalidate reports
   output logic                    inv_req,
   output logic [lg_l1i_lines-1:0] inv_line,
   input  logic                    inv_ack,

   // l2 writebacks to memory
   output logic                    mem_req,
   output logic [lg_l2_lines-1:0]  mem_line,
   input  logic                    mem_ack,

   output logic                    in_flush_mode
   );

   typedef logic [lg_l1i_lines-1:0] l1i_index_t;
   typedef logic [lg_l1d_lines-1:0] l1d_index_t;
   typedef logic [lg_l2_lines-1:0]  l2_index_t;

   logic start_l1i;
   logic start_l1d;
   logic start_l2;
   logic done_l1i;
   logic done_l1d;
   logic done_l2;

   // l1d to l2 writeback handshake
   logic       wb_req;
   logic       wb_ack;
   l1d_index_t wb_line;
   l2_index_t  wb_line_l2;

   assign wb_line_l2 = l2_index_t'(wb_line); // zero-extend into l2 index

   flush_sequencer seq0
     (
      .clk(clk),
      .reset(reset),
      .flush_req_l1i(flush_req_l1i),
      .flush_req_l1d(flush_req_l1d),
      .done_l1i(done_l1i),
      .done_l1d(done_l1d),
      .done_l2(done_l2),
      .start_l1i(start_l1i),
      .start_l1d(start_l1d),
      .start_l2(start_l2),
      .in_flush_mode(in_flush_mode)
      );

   line_walker #(.index_t(l1i_index_t)) l1i_walk0
     (
      .clk(clk),
      .reset(reset),
      .start(start_l1i),
      .mark_req(fill_req),
      .mark_index(fill_line),
      .emit_ack(inv_ack),
      .mark_ack(fill_ack),
      .emit_req(inv_req),
      .emit_index(inv_line),
      .done(done_l1i)
      );

   line_walker #(.index_t(l1d_index_t)) l1d_walk0
     (
      .clk(clk),
      .reset(reset),
      .start(start_l1d),
      .mark_req(store_req),
      .mark_index(store_line),
      .emit_ack(wb_ack),
      .mark_ack(store_ack),
      .emit_req(wb_req),
      .emit_index(wb_line),
      .done(done_l1d)
      );

   // dirty lines arrive from l1d even while this level is walking
   line_walker #(.index_t(l2_index_t)) l2_walk0
     (
      .clk(clk),
      .reset(reset),
      .start(start_l2),
      .mark_req(wb_req),
      .mark_index(wb_line_l2),
      .emit_ack(mem_ack),
      .mark_ack(wb_ack),
      .emit_req(mem_req),
      .emit_index(mem_line),
      .done(done_l2)
      );

endmodule

// ==== tb/hs_responder.sv ====
module hs_responder
  #(parameter int width = 4)
   (
   input  logic             clk,
   input  logic             reset,
   input  logic             req,
   input  logic [width-1:0] line,
   input  logic [1:0]       delay,
   output logic             ack,
   output logic             got,
   output logic [width-1:0] got_line
   );

   timeunit 1ns;
   timeprecision 1ps;

   logic [1:0] held;

   // four-phase sink, ack after req has been high for more than delay cycles
   always @(posedge clk)
   begin
      if (reset)
      begin
         ack <= 1'b0;
         got <= 1'b0;
         got_line <= '0;
         held <= '0;
      end
      else
      begin
         got <= 1'b0;
         if (ack)
         begin
            if (!req)
               ack <= 1'b0; // source released req
         end
         else if (req)
         begin
            if (held >= delay)
            begin
               ack <= 1'b1;
               got <= 1'b1; // one pulse per accepted line
               got_line <= line;
               held <= '0;
            end
            else
            begin
               held <= held + 1'b1;
            end
         end
      end
   end

endmodule

// ==== tb/tb_cache_flush.sv ====
module tb_cache_flush;

   timeunit 1ns;
   timeprecision 1ps;

   import flush_pkg::*;

   typedef logic [lg_l1i_lines_default-1:0] l1i_index_t;
   typedef logic [lg_l1d_lines_default-1:0] l1d_index_t;
   typedef logic [lg_l2_lines_default-1:0]  l2_index_t;

   localparam int num_l1i = 1 << lg_l1i_lines_default;
   localparam int num_l1d = 1 << lg_l1d_lines_default;
   localparam int num_l2 = 1 << lg_l2_lines_default;
   localparam int num_tests = 6;
   localparam int cycles_per_test = 2000;

   logic clk;
   logic reset;
   logic flush_req_l1i;
   logic flush_req_l1d;
   logic fill_req;
   l1i_index_t fill_line;
   logic fill_ack;
   logic store_req;
   l1d_index_t store_line;
   logic store_ack;
   logic inv_req;
   l1i_index_t inv_line;
   logic inv_ack;
   logic mem_req;
   l2_index_t mem_line;
   logic mem_ack;
   logic in_flush_mode;

   logic [1:0] inv_delay;
   logic [1:0] mem_delay;
   logic inv_got;
   logic mem_got;
   l1i_index_t inv_got_line;
   l2_index_t mem_got_line;

   logic [31:0] lfsr;
   string test_name;
   logic random_acks;

   // reference model state
   logic [num_l1i-1:0] l1i_valid;
   logic [num_l1d-1:0] l1d_dirty;
   logic [num_l2-1:0] l2_dirty;
   l1i_index_t exp_inv_q[$];
   l2_index_t exp_mem_q[$];

   cache_flush_top dut0
     (
      .clk(clk),
      .reset(reset),
      .flush_req_l1i(flush_req_l1i),
      .flush_req_l1d(flush_req_l1d),
      .fill_req(fill_req),
      .fill_line(fill_line),
      .fill_ack(fill_ack),
      .store_req(store_req),
      .store_line(store_line),
      .store_ack(store_ack),
      .inv_req(inv_req),
      .inv_line(inv_line),
      .inv_ack(inv_ack),
      .mem_req(mem_req),
      .mem_line(mem_line),
      .mem_ack(mem_ack),
      .in_flush_mode(in_flush_mode)
      );

   hs_responder #(.width(lg_l1i_lines_default)) inv_resp0
     (
      .clk(clk),
      .reset(reset),
      .req(inv_req),
      .line(inv_line),
      .delay(inv_delay),
      .ack(inv_ack),
      .got(inv_got),
      .got_line(inv_got_line)
      );

   hs_responder #(.width(lg_l2_lines_default)) mem_resp0
     (
      .clk(clk),
      .reset(reset),
      .req(mem_req),
      .line(mem_line),
      .delay(mem_delay),
      .ack(mem_ack),
      .got(mem_got),
      .got_line(mem_got_line)
      );

   always #2 clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic fb;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_l1i_line(input string what, input l1i_index_t exp, input l1i_index_t act);
      if (exp !== act)
         fail_run($sformatf("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp, act));
   endtask

   task automatic check_l2_line(input string what, input l2_index_t exp, input l2_index_t act);
      if (exp !== act)
         fail_run($sformatf("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp, act));
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (exp !== act)
         fail_run($sformatf("[ERROR] %s %s expected %b actual %b", test_name, what, exp, act));
   endtask

   task automatic check_state(input string what, input flush_state_t exp, input flush_state_t act);
      if (exp !== act)
         fail_run($sformatf("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp, act));
   endtask

   // every accepted transfer is matched against the head of its expected list
   always @(negedge clk)
   begin
      if (inv_got)
      begin
         if (exp_inv_q.size() == 0)
            fail_run($sformatf("%s: unexpected inv transfer of line %0d", test_name,
                               inv_got_line));
         else
            check_l1i_line("inv line", exp_inv_q.pop_front(), inv_got_line);
      end
      if (mem_got)
      begin
         check_flag("in_flush_mode at mem transfer", 1'b1, in_flush_mode);
         if (exp_mem_q.size() == 0)
            fail_run($sformatf("%s: unexpected mem transfer of line %0d", test_name,
                               mem_got_line));
         else
            check_l2_line("mem line", exp_mem_q.pop_front(), mem_got_line);
      end
   end

   // ack comes one cycle after the walker sees req
   task automatic do_fill(input l1i_index_t line);
      @(posedge clk);
      fill_req <= 1'b1;
      fill_line <= line;
      @(negedge clk);
      check_flag("fill_ack before req seen", 1'b0, fill_ack);
      @(negedge clk);
      check_flag("fill_ack one cycle after req", 1'b1, fill_ack);
      @(posedge clk);
      fill_req <= 1'b0;
      do @(negedge clk); while (fill_ack);
      l1i_valid[line] = 1'b1;
   endtask

   task automatic do_store(input l1d_index_t line);
      @(posedge clk);
      store_req <= 1'b1;
      store_line <= line;
      @(negedge clk);
      check_flag("store_ack before req seen", 1'b0, store_ack);
      @(negedge clk);
      check_flag("store_ack one cycle after req", 1'b1, store_ack);
      @(posedge clk);
      store_req <= 1'b0;
      do @(negedge clk); while (store_ack);
      l1d_dirty[line] = 1'b1;
   endtask

   task automatic random_fills(input int count);
      for (int n = 0; n < count; n++)
         do_fill(l1i_index_t'(take_bits(lg_l1i_lines_default)));
   endtask

   task automatic random_stores(input int count);
      for (int n = 0; n < count; n++)
         do_store(l1d_index_t'(take_bits(lg_l1d_lines_default)));
   endtask

   // expected transfers of one flush in ascending line order
   task automatic model_flush(input logic do_i, input logic do_d);
      int i;
      if (do_i)
      begin
         for (i = 0; i < num_l1i; i++)
            if (l1i_valid[i])
               exp_inv_q.push_back(l1i_index_t'(i));
         l1i_valid = '0;
      end
      if (do_d)
      begin
         for (i = 0; i < num_l1d; i++)
            if (l1d_dirty[i])
               l2_dirty[i] = 1'b1; // zero-extended index
         l1d_dirty = '0;
      end
      for (i = 0; i < num_l2; i++)
         if (l2_dirty[i])
            exp_mem_q.push_back(l2_index_t'(i));
      l2_dirty = '0;
   endtask

   task automatic run_flush(input logic do_i, input logic do_d, input logic interrupt);
      int cycles;
      model_flush(do_i, do_d);
      @(posedge clk);
      flush_req_l1i <= do_i;
      flush_req_l1d <= do_d;
      @(posedge clk);
      flush_req_l1i <= 1'b0;
      flush_req_l1d <= 1'b0;
      @(negedge clk);
      check_flag("in_flush_mode after request", 1'b1, in_flush_mode);
      cycles = 0;
      while (in_flush_mode)
      begin
         @(posedge clk);
         inv_delay <= random_acks ? 2'(take_bits(2)) : 2'd0;
         mem_delay <= random_acks ? 2'(take_bits(2)) : 2'd0;
         flush_req_l1i <= interrupt && (cycles == 5);
         flush_req_l1d <= interrupt && (cycles == 5);
         cycles++;
         @(negedge clk);
      end
      if (exp_inv_q.size() != 0)
         fail_run($sformatf("%s: %0d inv transfers missing after flush", test_name,
                            exp_inv_q.size()));
      if (exp_mem_q.size() != 0)
         fail_run($sformatf("%s: %0d mem transfers missing after flush", test_name,
                            exp_mem_q.size()));
      // flush must stay finished
      repeat (20)
      begin
         @(negedge clk);
         check_flag("in_flush_mode after flush", 1'b0, in_flush_mode);
      end
   endtask

   task automatic random_flush_kind(output logic do_i, output logic do_d);
      logic [1:0] kind;
      kind = 2'(take_bits(2));
      do_i = (kind != 2'd2);
      do_d = (kind != 2'd1);
   endtask

   initial
   begin
      repeat (num_tests * cycles_per_test) @(posedge clk);
      fail_run("watchdog timeout, the flush run did not finish in time");
   end

   initial
   begin
      logic do_i;
      logic do_d;
      clk = 1'b0;
      reset = 1'b1;
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      fill_req = 1'b0;
      fill_line = '0;
      store_req = 1'b0;
      store_line = '0;
      inv_delay = 2'd0;
      mem_delay = 2'd0;
      lfsr = 32'h057d_bc6e;
      random_acks = 1'b0;
      l1i_valid = '0;
      l1d_dirty = '0;
      l2_dirty = '0;
      test_name = "reset";

      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_flag("in_flush_mode", 1'b0, in_flush_mode);
      check_flag("inv_req", 1'b0, inv_req);
      check_flag("mem_req", 1'b0, mem_req);
      check_state("sequencer state", flush_idle, dut0.seq0.r_state);
      run_flush(1'b1, 1'b1, 1'b0); // nothing marked

      test_name = "l1i_only";
      random_fills(8 + int'(take_bits(3)));
      run_flush(1'b1, 1'b0, 1'b0);

      test_name = "l1d_only";
      random_stores(8 + int'(take_bits(3)));
      run_flush(1'b0, 1'b1, 1'b0);

      test_name = "both_same_cycle";
      random_fills(4 + int'(take_bits(3)));
      random_stores(4 + int'(take_bits(3)));
      run_flush(1'b1, 1'b1, 1'b0);

      test_name = "back_pressure";
      random_acks = 1'b1;
      random_fills(6 + int'(take_bits(3)));
      random_stores(6 + int'(take_bits(3)));
      run_flush(1'b1, 1'b1, 1'b0);
      random_flush_kind(do_i, do_d);
      run_flush(do_i, do_d, 1'b0); // no new marks

      test_name = "request_during_flush";
      random_fills(4 + int'(take_bits(2)));
      random_stores(4 + int'(take_bits(2)));
      random_flush_kind(do_i, do_d);
      run_flush(do_i, do_d, 1'b1);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== list.f ====
hw/flush_pkg.sv
hw/line_walker.sv
hw/flush_sequencer.sv
hw/cache_flush_top.sv
tb/hs_responder.sv
tb/tb_cache_flush.sv
